// ==== rtl/tdpBramArray_settings.svh ====
// **************************************************
// Dual-port BRAM array settings
// Geometry of the cell grid and the port address
// map, shared by the RTL and the testbench
// **************************************************

`ifndef TDP_BRAM_ARRAY_SETTINGS_SVH
`define TDP_BRAM_ARRAY_SETTINGS_SVH

// One behavioral cell
`define TDP_CELL_BITS       32
`define TDP_CELL_BYTES      4
`define TDP_CELL_WORDS      256

// Grid of cells
`define TDP_LANES           2
`define TDP_BANKS           4

// Port address map
`define TDP_ADDR_BITS       16
`define TDP_OFS_BITS        3
`define TDP_WORD_ADDR_BITS  10

// Derived widths
`define TDP_BYTE_BITS       (`TDP_CELL_BITS / `TDP_CELL_BYTES)
`define TDP_ARR_BITS        (`TDP_CELL_BITS * `TDP_LANES)
`define TDP_ARR_BYTES       (`TDP_CELL_BYTES * `TDP_LANES)
`define TDP_BANK_BITS       2
`define TDP_WORD_IDX_BITS   8
// First byte-address bit past the last bank
`define TDP_ERR_LSB         (`TDP_OFS_BITS + `TDP_WORD_ADDR_BITS)

`endif

// ==== rtl/tdpBramPkg.sv ====
// **************************************************
// Dual-port BRAM array types
// Port data, byte enables and the word address
// with its linear and bank/word views
// **************************************************

`include "tdpBramArray_settings.svh"

package tdpBramPkg;

  // Data word of one port, all lanes side by side
  typedef logic [`TDP_ARR_BITS-1:0] arrDataT;

  // One enable per byte of arrDataT
  typedef logic [`TDP_ARR_BYTES-1:0] byteEnT;

  // Word address seen two ways
  // linear is the word count from address 0,
  // split is the bank index on top of the word index in that bank
  typedef union packed {
    logic [`TDP_WORD_ADDR_BITS-1:0] linear;
    struct packed {
      logic [`TDP_BANK_BITS-1:0]     bank;
      logic [`TDP_WORD_IDX_BITS-1:0] word;
    } split;
  } wordAddrU;

endpackage

// ==== rtl/bramCell.sv ====
// **************************************************
// Behavioral dual-port BRAM cell
// 32-bit words, byte write enables and write-first
// read data on both ports, one clock of latency
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module bramCell #(
  parameter int Depth = `TDP_CELL_WORDS
) (
  input  logic                       A_PS,
  input  logic                       arstN,
  input  logic                       enA,
  input  logic [`TDP_CELL_BYTES-1:0] weA,
  input  logic [$clog2(Depth)-1:0]   addrA,
  input  logic [`TDP_CELL_BITS-1:0]  wrDataA,
  output logic [`TDP_CELL_BITS-1:0]  rdDataA,
  input  logic                       enB,
  input  logic [`TDP_CELL_BYTES-1:0] weB,
  input  logic [$clog2(Depth)-1:0]   addrB,
  input  logic [`TDP_CELL_BITS-1:0]  wrDataB,
  output logic [`TDP_CELL_BITS-1:0]  rdDataB
);

  logic [`TDP_CELL_BITS-1:0] mem [Depth];
  logic [`TDP_CELL_BITS-1:0] mergedA;
  logic [`TDP_CELL_BITS-1:0] mergedB;

  // Stored word with the enabled byte lanes replaced
  always_comb begin
    mergedA = mem[addrA];
    mergedB = mem[addrB];
    for (int i = 0; i < `TDP_CELL_BYTES; i++) begin
      if (weA[i]) begin
        mergedA[i*`TDP_BYTE_BITS +: `TDP_BYTE_BITS] = wrDataA[i*`TDP_BYTE_BITS +: `TDP_BYTE_BITS];
      end
      if (weB[i]) begin
        mergedB[i*`TDP_BYTE_BITS +: `TDP_BYTE_BITS] = wrDataB[i*`TDP_BYTE_BITS +: `TDP_BYTE_BITS];
      end
    end
  end

  // Array contents, no reset
  always_ff @(posedge A_PS) begin
    if (enA && |weA) begin
      mem[addrA] <= mergedA;
    end
    if (enB && |weB) begin
      mem[addrB] <= mergedB;
    end
  end

  // Write-first read data, held while the port is idle
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      rdDataA <= '0;
      rdDataB <= '0;
    end else begin
      if (enA) begin
        rdDataA <= mergedA;
      end
      if (enB) begin
        rdDataB <= mergedB;
      end
    end
  end

endmodule

// ==== rtl/bankAddrDecode.sv ====
// **************************************************
// Bank address decoder
// Splits a port byte address into bank and word
// index and flags addresses past the last bank
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module bankAddrDecode (
  input  logic [`TDP_ADDR_BITS-1:0]     addr,
  output logic [`TDP_BANK_BITS-1:0]     bankIdx,
  output logic [`TDP_WORD_IDX_BITS-1:0] wordIdx,
  output logic                          outOfRange
);

  tdpBramPkg::wordAddrU wordAddr;

  // Byte offset inside the port word is dropped here
  assign wordAddr.linear = addr[`TDP_OFS_BITS +: `TDP_WORD_ADDR_BITS];

  // Anything above the word address points past the last bank
  assign outOfRange = |addr[`TDP_ADDR_BITS-1:`TDP_ERR_LSB];

  always_comb begin
    bankIdx = wordAddr.split.bank;
    // Keep the bank index in range when the address is not
    if (outOfRange) begin
      bankIdx = '0;
    end
  end

  assign wordIdx = wordAddr.split.word;

endmodule

// ==== rtl/bramBank.sv ====
// **************************************************
// One bank of the dual-port BRAM array
// TDP_LANES cells side by side; write enables only
// reach the cells when a port selects this bank
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module bramBank (
  input  logic                          A_PS,
  input  logic                          arstN,
  input  logic                          bankSelA,
  input  logic                          enA,
  input  tdpBramPkg::byteEnT            wrEnA,
  input  logic [`TDP_WORD_IDX_BITS-1:0] wordIdxA,
  input  tdpBramPkg::arrDataT           wrDataA,
  output tdpBramPkg::arrDataT           rdDataA,
  input  logic                          bankSelB,
  input  logic                          enB,
  input  tdpBramPkg::byteEnT            wrEnB,
  input  logic [`TDP_WORD_IDX_BITS-1:0] wordIdxB,
  input  tdpBramPkg::arrDataT           wrDataB,
  output tdpBramPkg::arrDataT           rdDataB
);

  for (genvar l = 0; l < `TDP_LANES; l++) begin : gLane
    logic [`TDP_CELL_BYTES-1:0] laneWeA;
    logic [`TDP_CELL_BYTES-1:0] laneWeB;

    // Write gating per port, reads still run in every bank
    assign laneWeA = bankSelA ? wrEnA[l*`TDP_CELL_BYTES +: `TDP_CELL_BYTES] : '0;
    assign laneWeB = bankSelB ? wrEnB[l*`TDP_CELL_BYTES +: `TDP_CELL_BYTES] : '0;

    bramCell #(
      .Depth(`TDP_CELL_WORDS)
    ) u_cell (
      .A_PS   (A_PS),
      .arstN  (arstN),
      .enA    (enA),
      .weA    (laneWeA),
      .addrA  (wordIdxA),
      .wrDataA(wrDataA[l*`TDP_CELL_BITS +: `TDP_CELL_BITS]),
      .rdDataA(rdDataA[l*`TDP_CELL_BITS +: `TDP_CELL_BITS]),
      .enB    (enB),
      .weB    (laneWeB),
      .addrB  (wordIdxB),
      .wrDataB(wrDataB[l*`TDP_CELL_BITS +: `TDP_CELL_BITS]),
      .rdDataB(rdDataB[l*`TDP_CELL_BITS +: `TDP_CELL_BITS])
    );
  end

endmodule

// ==== rtl/readSelect.sv ====
// **************************************************
// Read data selector for one port
// Remembers the bank and error flag of each access
// and picks that bank's registered read data
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module readSelect (
  input  logic                                    A_PS,
  input  logic                                    arstN,
  input  logic                                    en,
  input  logic [`TDP_BANK_BITS-1:0]               bankIdx,
  input  logic                                    outOfRange,
  input  tdpBramPkg::arrDataT [`TDP_BANKS-1:0]    bankData,
  output tdpBramPkg::arrDataT                     rdData,
  output logic                                    addrErr
);

  logic [`TDP_BANK_BITS-1:0] bankIdxQ;

  // Captured on the same edge that the cells take the access
  always_ff @(posedge A_PS or negedge arstN) begin
    if (!arstN) begin
      bankIdxQ <= '0;
      addrErr  <= 1'b0;
    end else if (en) begin
      bankIdxQ <= bankIdx;
      addrErr  <= outOfRange;
    end
  end

  // Output follows the bank of the last access, not the live address
  assign rdData = bankData[bankIdxQ];

endmodule

// ==== rtl/tdpBramArray.sv ====
// **************************************************
// True dual-port BRAM array
// TDP_BANKS banks of TDP_LANES 32-bit cells behind
// two byte-addressed write-first ports
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module tdpBramArray (
  input  logic                      A_PS,
  input  logic                      arstN,
  // Port A
  input  logic                      enA,
  input  tdpBramPkg::byteEnT        wrEnA,
  input  logic [`TDP_ADDR_BITS-1:0] addrA,
  input  tdpBramPkg::arrDataT       wrDataA,
  output tdpBramPkg::arrDataT       rdDataA,
  output logic                      addrErrA,
  // Port B
  input  logic                      enB,
  input  tdpBramPkg::byteEnT        wrEnB,
  input  logic [`TDP_ADDR_BITS-1:0] addrB,
  input  tdpBramPkg::arrDataT       wrDataB,
  output tdpBramPkg::arrDataT       rdDataB,
  output logic                      addrErrB
);

  logic [`TDP_BANK_BITS-1:0]     bankIdxA;
  logic [`TDP_BANK_BITS-1:0]     bankIdxB;
  logic [`TDP_WORD_IDX_BITS-1:0] wordIdxA;
  logic [`TDP_WORD_IDX_BITS-1:0] wordIdxB;
  logic                          outOfRangeA;
  logic                          outOfRangeB;

  // Read data of every bank, per port
  wire tdpBramPkg::arrDataT [`TDP_BANKS-1:0] bankDataA;
  wire tdpBramPkg::arrDataT [`TDP_BANKS-1:0] bankDataB;

  bankAddrDecode u_decA (
    .addr      (addrA),
    .bankIdx   (bankIdxA),
    .wordIdx   (wordIdxA),
    .outOfRange(outOfRangeA)
  );

  bankAddrDecode u_decB (
    .addr      (addrB),
    .bankIdx   (bankIdxB),
    .wordIdx   (wordIdxB),
    .outOfRange(outOfRangeB)
  );

  for (genvar b = 0; b < `TDP_BANKS; b++) begin : gBank
    logic bankSelA;
    logic bankSelB;

    // Out-of-range addresses select no bank, so they write nothing
    assign bankSelA = (bankIdxA == `TDP_BANK_BITS'(b)) && !outOfRangeA;
    assign bankSelB = (bankIdxB == `TDP_BANK_BITS'(b)) && !outOfRangeB;

    bramBank u_bank (
      .A_PS    (A_PS),
      .arstN   (arstN),
      .bankSelA(bankSelA),
      .enA     (enA),
      .wrEnA   (wrEnA),
      .wordIdxA(wordIdxA),
      .wrDataA (wrDataA),
      .rdDataA (bankDataA[b]),
      .bankSelB(bankSelB),
      .enB     (enB),
      .wrEnB   (wrEnB),
      .wordIdxB(wordIdxB),
      .wrDataB (wrDataB),
      .rdDataB (bankDataB[b])
    );
  end

  readSelect u_selA (
    .A_PS      (A_PS),
    .arstN     (arstN),
    .en        (enA),
    .bankIdx   (bankIdxA),
    .outOfRange(outOfRangeA),
    .bankData  (bankDataA),
    .rdData    (rdDataA),
    .addrErr   (addrErrA)
  );

  readSelect u_selB (
    .A_PS      (A_PS),
    .arstN     (arstN),
    .en        (enB),
    .bankIdx   (bankIdxB),
    .outOfRange(outOfRangeB),
    .bankData  (bankDataB),
    .rdData    (rdDataB),
    .addrErr   (addrErrB)
  );

endmodule

// ==== tests/tdpBramArray_sva.sv ====
// **************************************************
// Assertions for the dual-port BRAM array
// Error flag behavior and bank index range, bound
// into the top level
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module tdpBramArraySva (
  input logic                      A_PS,
  input logic                      arstN,
  input logic                      enA,
  input logic                      enB,
  input logic                      outOfRangeA,
  input logic                      outOfRangeB,
  input logic                      addrErrA,
  input logic                      addrErrB,
  input logic [`TDP_ADDR_BITS-1:0] addrA,
  input logic [`TDP_ADDR_BITS-1:0] addrB,
  input logic [`TDP_BANK_BITS-1:0] selIdxA,
  input logic [`TDP_BANK_BITS-1:0] selIdxB
);

  // Flags start low during reset and in the first cycle after it
  errLowAfterReset: assert property (@(posedge A_PS)
    (!arstN || $rose(arstN)) |-> (!addrErrA && !addrErrB))
    else $error("addrErr not low around reset");

  // A flag only rises after an enabled out-of-range access
  errRiseA: assert property (@(posedge A_PS) disable iff (!arstN)
    $rose(addrErrA) |-> $past(enA && outOfRangeA))
    else $error("addrErrA rose without an out-of-range access");

  errRiseB: assert property (@(posedge A_PS) disable iff (!arstN)
    $rose(addrErrB) |-> $past(enB && outOfRangeB))
    else $error("addrErrB rose without an out-of-range access");

  // Registered bank index is the bank of the last access or 0 past the last bank
  bankRangeA: assert property (@(posedge A_PS) disable iff (!arstN)
    enA |=> (selIdxA == ($past(outOfRangeA) ? '0 :
                         $past(addrA[`TDP_ERR_LSB-1 -: `TDP_BANK_BITS]))))
    else $error("port A bank index does not match its access");

  bankRangeB: assert property (@(posedge A_PS) disable iff (!arstN)
    enB |=> (selIdxB == ($past(outOfRangeB) ? '0 :
                         $past(addrB[`TDP_ERR_LSB-1 -: `TDP_BANK_BITS]))))
    else $error("port B bank index does not match its access");

endmodule

bind tdpBramArray tdpBramArraySva u_sva (
  .A_PS       (A_PS),
  .arstN      (arstN),
  .enA        (enA),
  .enB        (enB),
  .outOfRangeA(outOfRangeA),
  .outOfRangeB(outOfRangeB),
  .addrErrA   (addrErrA),
  .addrErrB   (addrErrB),
  .addrA      (addrA),
  .addrB      (addrB),
  .selIdxA    (u_selA.bankIdxQ),
  .selIdxB    (u_selB.bankIdxQ)
);

// ==== tests/tdpBramArrayTb.sv ====
// **************************************************
// Testbench for the dual-port BRAM array
// Table-driven stimulus on both ports, checked
// against a shadow memory of the whole array
// **************************************************

`timescale 1ns/1ns
`include "tdpBramArray_settings.svh"

module tdpBramArrayTb;

  typedef struct packed {
    logic                      enA;
    tdpBramPkg::byteEnT        wrEnA;
    logic [`TDP_ADDR_BITS-1:0] addrA;
    tdpBramPkg::arrDataT       wrDataA;
    logic                      enB;
    tdpBramPkg::byteEnT        wrEnB;
    logic [`TDP_ADDR_BITS-1:0] addrB;
    tdpBramPkg::arrDataT       wrDataB;
  } rowT;

  logic A_PS;
  logic arstN;
  logic enA, enB;
  tdpBramPkg::byteEnT wrEnA, wrEnB;
  logic [`TDP_ADDR_BITS-1:0] addrA, addrB;
  tdpBramPkg::arrDataT wrDataA, wrDataB, rdDataA, rdDataB;
  logic addrErrA, addrErrB;

  rowT rowTable[$];
  bit tableReady = 1'b0;
  logic [31:0] lfsr = 32'h8b86_b298;

  // Shadow of all 1024 port words; valid marks fully known words
  tdpBramPkg::arrDataT shadow [1 << `TDP_WORD_ADDR_BITS];
  bit shadowValid [1 << `TDP_WORD_ADDR_BITS];

  tdpBramPkg::arrDataT expRdA, expRdB;
  logic knownA = 1'b0, knownB = 1'b0;
  logic expErrA = 1'b0, expErrB = 1'b0;

  tdpBramArray u_tdpBramArray (.*);

  initial begin
    A_PS = 1'b0;
    forever #2 A_PS = ~A_PS;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [`TDP_ADDR_BITS-1:0] byteAddr(input logic [1:0] bank,
                                                         input logic [7:0] word);
    return {3'b000, bank, word, 3'b000};
  endfunction

  function automatic tdpBramPkg::arrDataT pattern(input logic [15:0] a, input logic [15:0] tag);
    return {a, ~a, a ^ tag, tag};
  endfunction

  task automatic addRow(input logic eA, input tdpBramPkg::byteEnT wA, input logic [15:0] aA,
                        input tdpBramPkg::arrDataT dA, input logic eB,
                        input tdpBramPkg::byteEnT wB, input logic [15:0] aB,
                        input tdpBramPkg::arrDataT dB);
    rowTable.push_back('{eA, wA, aA, dA, eB, wB, aB, dB});
  endtask

  task automatic buildTable();
    logic [15:0] aA, aB;
    // Full words on A in every bank, then read back on A
    for (int b = 0; b < `TDP_BANKS; b++) begin
      addRow(1, '1, byteAddr(b, 8'h10 + b), pattern(byteAddr(b, 8'h10 + b), 16'h1111),
             0, '0, '0, '0);
    end
    for (int b = 0; b < `TDP_BANKS; b++) begin
      addRow(1, '0, byteAddr(b, 8'h10 + b), '0, 0, '0, '0, '0);
    end
    // Byte merges, including a lane split, then a plain read
    addRow(1, 8'h0f, byteAddr(1, 8'h11), 64'hdead_beef_cafe_f00d, 0, '0, '0, '0);
    addRow(1, 8'ha0, byteAddr(1, 8'h11), 64'h1122_3344_5566_7788, 0, '0, '0, '0);
    addRow(1, 8'h42, byteAddr(1, 8'h11), 64'h99aa_bbcc_ddee_ff00, 0, '0, '0, '0);
    addRow(1, '0, byteAddr(1, 8'h11), '0, 0, '0, '0, '0);
    // Cross-port traffic in every bank, lane halves as well
    for (int b = 0; b < `TDP_BANKS; b++) begin
      addRow(1, '1, byteAddr(b, 8'h40), pattern(byteAddr(b, 8'h40), 16'h2222),
             1, '1, byteAddr(b, 8'h80), pattern(byteAddr(b, 8'h80), 16'h3333));
      addRow(1, 8'hf0, byteAddr(b, 8'h80), 64'h0bad_f00d_0000_0000,
             1, 8'h0f, byteAddr(b, 8'h40), 64'h0000_0000_7777_5555);
      addRow(1, '0, byteAddr(b, 8'h40), '0, 1, '0, byteAddr(b, 8'h80), '0);
    end
    // Out-of-range writes alias onto written words and must not land
    addRow(1, '1, 16'h2000 | byteAddr(0, 8'h10), '1, 0, '0, '0, '0);
    addRow(1, '0, byteAddr(0, 8'h10), '0, 1, '1, 16'h8000 | byteAddr(0, 8'h40), '0);
    addRow(0, '0, '0, '0, 0, '0, '0, '0);
    addRow(0, '0, '0, '0, 1, '0, byteAddr(0, 8'h40), '0);
    // Idle cycles hold both outputs
    addRow(1, '0, byteAddr(3, 8'h13), '0, 1, '0, byteAddr(1, 8'h11), '0);
    repeat (3) addRow(0, '1, 16'hffff, '1, 0, '1, 16'hffff, '1);
    // Fill the random window of every bank with known words
    for (int b = 0; b < `TDP_BANKS; b++) begin
      for (int w = 0; w < 16; w += 2) begin
        addRow(1, '1, byteAddr(2'(b), 8'(w)), pattern(byteAddr(2'(b), 8'(w)), 16'h4444),
               1, '1, byteAddr(2'(b), 8'(w + 1)), pattern(byteAddr(2'(b), 8'(w + 1)), 16'h5555));
      end
    end
    // Random mixed traffic on a small window of every bank
    for (int n = 0; n < 150; n++) begin
      aA = byteAddr(randBits(2), 8'(randBits(4))) | 16'(randBits(3));
      aB = byteAddr(randBits(2), 8'(randBits(4))) | 16'(randBits(3));
      if (aA[12:3] == aB[12:3]) begin
        aB[3] = ~aB[3];
      end
      addRow(randBits(2) != 0, randBits(1) ? randBits(8) : '0, aA, randBits(64),
             randBits(2) != 0, randBits(1) ? randBits(8) : '0, aB, randBits(64));
    end
  endtask

  task automatic predictPort(input logic en, input tdpBramPkg::byteEnT we,
                             input logic [15:0] addr, input tdpBramPkg::arrDataT data,
                             inout tdpBramPkg::arrDataT expRd, inout logic known,
                             inout logic expErr);
    int w;
    tdpBramPkg::arrDataT merged;
    if (en) begin
      if (|addr[`TDP_ADDR_BITS-1:`TDP_ERR_LSB]) begin
        expErr = 1'b1;
        known = 1'b0;
      end else begin
        w = addr[`TDP_ERR_LSB-1:`TDP_OFS_BITS];
        merged = shadow[w];
        for (int i = 0; i < 8; i++) begin
          if (we[i]) merged[i*8 +: 8] = data[i*8 +: 8];
        end
        known = shadowValid[w] || (we == '1);
        shadow[w] = merged;
        shadowValid[w] = known;
        expRd = merged;
        expErr = 1'b0;
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic checkPorts();
    checkValue("addrErrA", addrErrA, expErrA);
    checkValue("addrErrB", addrErrB, expErrB);
    if (knownA) checkValue("rdDataA", rdDataA, expRdA);
    if (knownB) checkValue("rdDataB", rdDataB, expRdB);
  endtask

  task automatic driveRow(input rowT r);
    {enA, wrEnA, addrA, wrDataA} = {r.enA, r.wrEnA, r.addrA, r.wrDataA};
    {enB, wrEnB, addrB, wrDataB} = {r.enB, r.wrEnB, r.addrB, r.wrDataB};
    predictPort(r.enA, r.wrEnA, r.addrA, r.wrDataA, expRdA, knownA, expErrA);
    predictPort(r.enB, r.wrEnB, r.addrB, r.wrDataB, expRdB, knownB, expErrB);
  endtask

  // Watchdog sized from the table, the reset and a margin
  initial begin
    longint limitNs;
    wait (tableReady);
    limitNs = (16 + rowTable.size() + 4) * 4 + 100;
    #(limitNs);
    $display("Watchdog expired before the table finished");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    arstN = 1'b0;
    driveRow('0);
    buildTable();
    tableReady = 1'b1;
    repeat (16) @(posedge A_PS);
    #1 arstN = 1'b1;
    foreach (rowTable[i]) begin
      @(posedge A_PS);
      #1;
      checkPorts();
      driveRow(rowTable[i]);
    end
    @(posedge A_PS);
    #1;
    checkPorts();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== tdpBramArray.f ====
+incdir+rtl
rtl/tdpBramPkg.sv
rtl/bramCell.sv
rtl/bankAddrDecode.sv
rtl/bramBank.sv
rtl/readSelect.sv
rtl/tdpBramArray.sv
tests/tdpBramArray_sva.sv
tests/tdpBramArrayTb.sv
